/* Bender.yml */
package:
  name: rv32i_core

sources:
  - hdl/CorePkg.sv
  - hdl/Alu.sv
  - hdl/RegsFile.sv
  - hdl/InstrSplit.sv
  - hdl/PcUnit.sv
  - hdl/Decode.sv
  - hdl/CoreTop.sv
  - target: test
    files:
      - testbench/CoreTb.sv

/* hdl/Alu.sv */
`timescale 1ns/1ps
`default_nettype none

module Alu
	import CorePkg::*;
(
	input	AluOpT					op,
	input	logic [DataWidth-1:0]	x,
	input	logic [DataWidth-1:0]	y,
	output	logic [DataWidth-1:0]	result
);

	logic [4:0]	shamt;
	logic		lessSigned;
	logic		lessUnsigned;
	logic		equal;
	logic		isCompare;

	assign shamt = y[4:0]; // only low 5 bits count
	assign lessSigned = $signed(x) < $signed(y);
	assign lessUnsigned = x < y;
	assign equal = x == y;

	assign isCompare = op inside {LessSigned, LessUnsigned, GreaterEqualSigned,
		GreaterEqualUnsigned, Equal, NotEqual};

	always_comb
	begin
		case (op)
			Add:					result = x + y;
			Sub:					result = x - y;
			ShiftLeft:				result = x << shamt;
			ShiftRightLogic:		result = x >> shamt;
			ShiftRightArith:		result = $signed(x) >>> shamt;
			LessSigned:				result = DataWidth'(lessSigned);
			LessUnsigned:			result = DataWidth'(lessUnsigned);
			GreaterEqualSigned:		result = DataWidth'(!lessSigned);
			GreaterEqualUnsigned:	result = DataWidth'(!lessUnsigned);
			Equal:					result = DataWidth'(equal);
			NotEqual:				result = DataWidth'(!equal);
			Xor:					result = x ^ y;
			Or:						result = x | y;
			And:					result = x & y;
			default:				result = '0;
		endcase
	end

	// branch decision in Decode only looks at bit 0
	always_comb
	begin
		if (isCompare)
		begin
			assert final (result <= 1)
				else $error("compare result %0h is not 0 or 1", result);
		end
	end

endmodule

`default_nettype wire

/* hdl/CorePkg.sv */
`default_nettype none

package CorePkg;

	localparam int DataWidth = 32;
	localparam int RegFieldWidth = 5; // rd, rs1, rs2 fields

	typedef enum logic [6:0]
	{
		OpReg		= 7'b0110011,
		OpImm		= 7'b0010011,
		OpLoad		= 7'b0000011,
		OpStore		= 7'b0100011,
		OpBranch	= 7'b1100011,
		OpJal		= 7'b1101111,
		OpJalr		= 7'b1100111,
		OpLui		= 7'b0110111,
		OpAuipc		= 7'b0010111
	} OpcodeT;

	typedef enum logic [3:0]
	{
		Add,
		Sub,
		ShiftLeft,
		ShiftRightLogic,
		ShiftRightArith,
		LessSigned,
		LessUnsigned,
		GreaterEqualSigned,
		GreaterEqualUnsigned,
		Equal,
		NotEqual,
		Xor,
		Or,
		And
	} AluOpT;

	typedef enum logic [2:0]
	{
		PcClear,
		PcAdd4,
		PcAddImm, // pc + target
		PcSetTarget // jump to target, bit 0 cleared
	} PcOpT;

	// retire action of the current instruction
	typedef enum logic [2:0]
	{
		Idle, // illegal or unsupported, nothing retires
		RegsWrite,
		MemToRegs,
		MemWrite,
		PcWrite
	} StateT;

	typedef struct packed
	{
		OpcodeT						opcode;
		logic [2:0]					func3;
		logic [6:0]					func7;
		logic [RegFieldWidth-1:0]	rd;
		logic [RegFieldWidth-1:0]	rs1;
		logic [RegFieldWidth-1:0]	rs2;
		logic [DataWidth-1:0]		imm; // already sign-extended
	} InstrFieldsT;

	typedef struct packed
	{
		PcOpT					pcOp;
		logic [DataWidth-1:0]	target;
	} PcCtrlT;

	typedef struct packed
	{
		logic [DataWidth-1:0]	addr;
		logic					writeEnable; // one-cycle store strobe
		logic					readEnable;
		logic [3:0]				byteMask;
		logic [DataWidth-1:0]	writeData;
	} DataBusT;

endpackage

`default_nettype wire

/* hdl/CoreTop.sv */
`timescale 1ns/1ps
`default_nettype none

module CoreTop
	import CorePkg::*;
#(
	parameter logic [DataWidth-1:0]	ResetPc = 32'h0,
	parameter int					RegCount = 32
)
(
	input	logic					clk,
	input	logic					reset,
	output	logic [DataWidth-1:0]	pc,
	input	logic [DataWidth-1:0]	instr, // returned in the same cycle
	output	DataBusT				dataBus,
	input	logic [DataWidth-1:0]	dataReadData
);

	InstrFieldsT	fields;
	PcCtrlT			pcCtrl;
	logic			pcWriteEnable;

	InstrSplit u_InstrSplit (
		.instr(instr),
		.fields(fields)
	);

	Decode #(.RegCount(RegCount)) u_Decode (
		.clk(clk),
		.reset(reset),
		.fields(fields),
		.pc(pc),
		.dataReadData(dataReadData),
		.pcCtrl(pcCtrl),
		.pcWriteEnable(pcWriteEnable),
		.dataBus(dataBus)
	);

	PcUnit #(.ResetPc(ResetPc)) u_PcUnit (
		.clk(clk),
		.reset(reset),
		.ctrl(pcCtrl),
		.writeEnable(pcWriteEnable),
		.pc(pc)
	);

endmodule

`default_nettype wire

/* hdl/Decode.sv */
`timescale 1ns/1ps
`default_nettype none

module Decode
	import CorePkg::*;
#(
	parameter int RegCount = 32
)
(
	input	logic					clk,
	input	logic					reset,
	input	InstrFieldsT			fields,
	input	logic [DataWidth-1:0]	pc,
	input	logic [DataWidth-1:0]	dataReadData,
	output	PcCtrlT					pcCtrl,
	output	logic					pcWriteEnable,
	output	DataBusT				dataBus
);

	localparam int NumWidth = $clog2(RegCount);

	AluOpT					aluOp;
	logic [DataWidth-1:0]	aluX;
	logic [DataWidth-1:0]	aluY;
	logic [DataWidth-1:0]	aluResult;
	logic [DataWidth-1:0]	regReadData0;
	logic [DataWidth-1:0]	regReadData1;
	logic					regsWriteEnable;
	logic [DataWidth-1:0]	regWriteData;
	logic [DataWidth-1:0]	pcPlus4;
	logic [DataWidth-1:0]	loadByte;
	logic [DataWidth-1:0]	loadHalf;
	logic [DataWidth-1:0]	storeData;
	logic [3:0]				storeMask;
	StateT					decodedState;
	StateT					state;

	function automatic AluOpT arithOp(input logic [2:0] func3, input logic alt);
		case (func3)
			3'd0:		return alt ? Sub : Add;
			3'd1:		return ShiftLeft;
			3'd2:		return LessSigned;
			3'd3:		return LessUnsigned;
			3'd4:		return Xor;
			3'd5:		return alt ? ShiftRightArith : ShiftRightLogic;
			3'd6:		return Or;
			default:	return And;
		endcase
	endfunction

	Alu u_Alu (.op(aluOp), .x(aluX), .y(aluY), .result(aluResult));

	RegsFile #(.RegCount(RegCount)) u_RegsFile (
		.clk(clk),
		.reset(reset),
		.readNum0(fields.rs1[NumWidth-1:0]),
		.readNum1(fields.rs2[NumWidth-1:0]),
		.readData0(regReadData0),
		.readData1(regReadData1),
		.writeEnable(regsWriteEnable),
		.writeNum(fields.rd[NumWidth-1:0]),
		.writeData(regWriteData)
	);

	assign pcPlus4 = pc + 32'd4;
	assign loadByte = dataReadData >> {aluResult[1:0], 3'b000}; // addressed lane to bit 0
	assign loadHalf = dataReadData >> {aluResult[1], 4'b0000};

	always_comb
	begin
		aluOp = Add;
		aluX = regReadData0;
		aluY = fields.imm;
		pcCtrl = '{pcOp: PcAdd4, target: fields.imm};
		regWriteData = aluResult;
		storeData = regReadData1;
		storeMask = 4'b1111;
		decodedState = Idle;
		case (fields.opcode)
			OpReg:
			begin
				aluY = regReadData1;
				aluOp = arithOp(fields.func3, fields.func7[5]);
				decodedState = RegsWrite;
			end
			OpImm:
			begin
				// no subi, func7 bit only selects srai
				aluOp = (fields.func3 == 3'd0) ? Add : arithOp(fields.func3, fields.func7[5]);
				decodedState = RegsWrite;
			end
			OpLoad:
			begin
				decodedState = MemToRegs;
				case (fields.func3)
					3'd0:		regWriteData = {{24{loadByte[7]}}, loadByte[7:0]}; // lb
					3'd1:		regWriteData = {{16{loadHalf[15]}}, loadHalf[15:0]}; // lh
					3'd2:		regWriteData = dataReadData; // lw
					3'd4:		regWriteData = {24'b0, loadByte[7:0]}; // lbu
					3'd5:		regWriteData = {16'b0, loadHalf[15:0]}; // lhu
					default:	decodedState = Idle;
				endcase
			end
			OpStore:
			begin
				decodedState = MemWrite;
				case (fields.func3)
					3'd0: // sb
					begin
						storeData = {4{regReadData1[7:0]}};
						storeMask = 4'b0001 << aluResult[1:0];
					end
					3'd1: // sh
					begin
						storeData = {2{regReadData1[15:0]}};
						storeMask = 4'b0011 << {aluResult[1], 1'b0};
					end
					3'd2:		storeMask = 4'b1111; // sw
					default:	decodedState = Idle;
				endcase
			end
			OpBranch:
			begin
				aluY = regReadData1;
				decodedState = PcWrite;
				case (fields.func3)
					3'd0:		aluOp = Equal;
					3'd1:		aluOp = NotEqual;
					3'd4:		aluOp = LessSigned;
					3'd5:		aluOp = GreaterEqualSigned;
					3'd6:		aluOp = LessUnsigned;
					3'd7:		aluOp = GreaterEqualUnsigned;
					default:	decodedState = Idle;
				endcase
				pcCtrl.pcOp = aluResult[0] ? PcAddImm : PcAdd4;
			end
			OpJal, OpJalr:
			begin
				if (fields.opcode == OpJal)
					aluX = pc; // jalr keeps rs1
				pcCtrl = '{pcOp: PcSetTarget, target: aluResult};
				regWriteData = pcPlus4; // link
				decodedState = RegsWrite;
			end
			OpLui:
			begin
				regWriteData = fields.imm;
				decodedState = RegsWrite;
			end
			OpAuipc:
			begin
				aluX = pc;
				decodedState = RegsWrite;
			end
			default: decodedState = Idle;
		endcase
	end

	assign state = reset ? Idle : decodedState; // no strobes while in reset

	assign regsWriteEnable = (state == RegsWrite) || (state == MemToRegs);
	assign pcWriteEnable = state != Idle;

	assign dataBus = '{
		addr: aluResult,
		writeEnable: (state == MemWrite),
		readEnable: (state == MemToRegs),
		byteMask: storeMask,
		writeData: storeData
	};

endmodule

`default_nettype wire

/* hdl/InstrSplit.sv */
`timescale 1ns/1ps
`default_nettype none

module InstrSplit
	import CorePkg::*;
(
	input	logic [DataWidth-1:0]	instr,
	output	InstrFieldsT			fields
);

	OpcodeT opcode;

	assign opcode = OpcodeT'(instr[6:0]);

	always_comb
	begin
		fields.opcode = opcode;
		fields.func3 = instr[14:12];
		fields.func7 = instr[31:25];
		fields.rd = instr[11:7];
		fields.rs1 = instr[19:15];
		fields.rs2 = instr[24:20];

		case (opcode)
			OpImm, OpLoad, OpJalr: // I format
				fields.imm = {{20{instr[31]}}, instr[31:20]};
			OpStore: // S format
				fields.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			OpBranch: // B format
				fields.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			OpLui, OpAuipc: // U format
				fields.imm = {instr[31:12], 12'b0};
			OpJal: // J format
				fields.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			default:
				fields.imm = '0; // R format has none
		endcase
	end

endmodule

`default_nettype wire

/* hdl/PcUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module PcUnit
	import CorePkg::*;
#(
	parameter logic [DataWidth-1:0] ResetPc = 32'h0
)
(
	input	logic					clk,
	input	logic					reset,
	input	PcCtrlT					ctrl,
	input	logic					writeEnable,
	output	logic [DataWidth-1:0]	pc
);

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= ResetPc;
		else if (writeEnable) // low on Idle, core stalls here
		begin
			case (ctrl.pcOp)
				PcClear:		pc <= ResetPc;
				PcAdd4:			pc <= pc + 32'd4;
				PcAddImm:		pc <= pc + ctrl.target;
				PcSetTarget:	pc <= {ctrl.target[DataWidth-1:1], 1'b0};
				default:		pc <= pc;
			endcase
		end
	end

	// jump and branch targets from Decode must land on word boundaries
	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc %0h is not word aligned", pc);

endmodule

`default_nettype wire

/* hdl/RegsFile.sv */
`timescale 1ns/1ps
`default_nettype none

module RegsFile
	import CorePkg::*;
#(
	parameter int RegCount = 32
)
(
	input	logic							clk,
	input	logic							reset,
	input	logic [$clog2(RegCount)-1:0]	readNum0,
	input	logic [$clog2(RegCount)-1:0]	readNum1,
	output	logic [DataWidth-1:0]			readData0,
	output	logic [DataWidth-1:0]			readData1,
	input	logic							writeEnable,
	input	logic [$clog2(RegCount)-1:0]	writeNum,
	input	logic [DataWidth-1:0]			writeData
);

	logic [DataWidth-1:0] regs [RegCount];

	assign readData0 = regs[readNum0];
	assign readData1 = regs[readNum1];

	always_ff @(posedge clk)
	begin
		if (reset)
			regs <= '{default: '0};
		else if (writeEnable && writeNum != '0) // x0 never written
			regs[writeNum] <= writeData;
	end

	// x0 must survive every write Decode issues, including rd = 0
	assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
		else $error("register zero changed to %0h", regs[0]);

endmodule

`default_nettype wire

/* sources.f */
hdl/CorePkg.sv
hdl/Alu.sv
hdl/RegsFile.sv
hdl/InstrSplit.sv
hdl/PcUnit.sv
hdl/Decode.sv
hdl/CoreTop.sv
testbench/CoreTb.sv

/* testbench/CoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module CoreTb
	import CorePkg::*;
();

	localparam logic [DataWidth-1:0]	ResetPc = 32'h0;
	localparam int						RegCount = 32;
	localparam int						MemWords = 64;
	localparam int						ResetTimeout = 10; // cycles

	// one traced cycle after reset
	typedef struct packed
	{
		logic [DataWidth-1:0]	pc;
		logic					store;
		logic [DataWidth-1:0]	addr;
		logic [3:0]				byteMask;
		logic [DataWidth-1:0]	writeData;
	} TraceEntryT;

	logic					clk;
	logic					reset;
	logic [DataWidth-1:0]	pc;
	logic [DataWidth-1:0]	instr;
	DataBusT				dataBus;
	logic [DataWidth-1:0]	dataReadData;

	logic [DataWidth-1:0]	progMem [MemWords];
	logic [DataWidth-1:0]	dataMem [MemWords];
	TraceEntryT				trace [$];
	int						errorCount;
	int						checkCount;
	int						seed;

	CoreTop #(.ResetPc(ResetPc), .RegCount(RegCount)) u_CoreTop (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.dataBus(dataBus),
		.dataReadData(dataReadData)
	);

	always #50 clk = ~clk;

	assign instr = progMem[pc[7:2]]; // same-cycle fetch
	assign dataReadData = dataMem[dataBus.addr[7:2]];

	// data memory model with byte lanes under byteMask
	always @(posedge clk)
	begin
		if (dataBus.writeEnable)
		begin
			for (int lane = 0; lane < 4; lane++)
			begin
				if (dataBus.byteMask[lane])
					dataMem[dataBus.addr[7:2]][8*lane +: 8] <= dataBus.writeData[8*lane +: 8];
			end
		end
	end

	initial
	begin
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

	// RV32I load major opcode
	function automatic logic isLoad(input logic [DataWidth-1:0] word);
		return word[6:0] == 7'b0000011;
	endfunction

	task automatic checkValue(input string name, input logic [DataWidth-1:0] expected,
		input logic [DataWidth-1:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic finishRun();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic loadStimulus(output logic ok);
		int						fd;
		int						code;
		int						progCount;
		logic [8*8-1:0]			tag;
		logic [8*128-1:0]		line;
		logic [DataWidth-1:0]	words [5];
		TraceEntryT				entry;
		ok = 1'b1;
		progCount = 0;
		fd = $fopen("testbench/core_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file testbench/core_stimulus.txt");
			errorCount++;
			ok = 1'b0;
		end
		else
		begin
			while (!$feof(fd))
			begin
				code = $fscanf(fd, "%s", tag);
				if (code == 1)
				begin
					if (tag == "#")
						code = $fgets(line, fd); // rest of a comment line
					else if (tag == "P" && progCount + 4 <= MemWords)
					begin
						code = $fscanf(fd, "%h %h %h %h", words[0], words[1], words[2],
							words[3]);
						for (int k = 0; k < 4; k++)
							progMem[progCount + k] = words[k];
						progCount += 4;
					end
					else if (tag == "D")
					begin
						code = $fscanf(fd, "%h %h", words[0], words[1]);
						dataMem[words[0][5:0]] = words[1];
					end
					else if (tag == "T")
					begin
						code = $fscanf(fd, "%h %h %h %h %h", words[0], words[1], words[2],
							words[3], words[4]);
						entry.pc = words[0];
						entry.store = words[1][0];
						entry.addr = words[2];
						entry.byteMask = words[3][3:0];
						entry.writeData = words[4];
						trace.push_back(entry);
					end
					else
					begin
						$display("unexpected record %s in the stimulus file", tag);
						errorCount++;
					end
				end
			end
			$fclose(fd);
			if (trace.size() == 0)
			begin
				$display("the stimulus file holds no trace entries");
				errorCount++;
				ok = 1'b0;
			end
		end
	endtask

	task automatic waitForResetPc(output logic ok);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (pc !== ResetPc && cycles < ResetTimeout);
		ok = (pc === ResetPc);
		if (!ok)
		begin
			$display("timeout: pc never took the reset value while reset was held");
			errorCount++;
		end
	endtask

	task automatic watchReset(output logic ok);
		int cycles;
		cycles = 0;
		while (reset === 1'b1 && cycles < ResetTimeout)
		begin
			checkValue("pc", ResetPc, pc);
			checkValue("dataBus.writeEnable", 1'b0, dataBus.writeEnable);
			checkValue("dataBus.readEnable", 1'b0, dataBus.readEnable);
			@(negedge clk);
			cycles++;
		end
		ok = (reset !== 1'b1);
		if (!ok)
		begin
			$display("timeout: reset was never released");
			errorCount++;
		end
	endtask

	// sampled on the falling edge once outputs settle
	task automatic followTrace();
		for (int i = 0; i < trace.size(); i++)
		begin
			checkValue("pc", trace[i].pc, pc);
			checkValue("dataBus.writeEnable", trace[i].store, dataBus.writeEnable);
			checkValue("dataBus.readEnable", isLoad(progMem[trace[i].pc[7:2]]),
				dataBus.readEnable);
			if (trace[i].store)
			begin
				checkValue("dataBus.addr", trace[i].addr, dataBus.addr);
				checkValue("dataBus.byteMask", trace[i].byteMask, dataBus.byteMask);
				checkValue("dataBus.writeData", trace[i].writeData, dataBus.writeData);
			end
			@(negedge clk);
		end
	endtask

	initial
	begin
		logic ok;
		clk = 1'b0;
		reset = 1'b1;
		errorCount = 0;
		checkCount = 0;
		seed = 81683;
		for (int i = 0; i < MemWords; i++)
		begin
			progMem[i] = {24'(i), 8'hff}; // unsupported opcode 7f
			dataMem[i] = $random(seed);
		end
		loadStimulus(ok);
		if (ok)
			waitForResetPc(ok);
		if (ok)
			watchReset(ok);
		if (ok)
			followTrace();
		finishRun();
	end

endmodule

`default_nettype wire

/* testbench/core_stimulus.txt */
# P: four program words each, from the reset pc upward; D: data word index and value
# T: pc, store strobe, store address, byte mask, write data for each cycle after reset
P 123450b7 67808093 ffd00113 402081b3
P 04302023 0020b233 04402223 40115293
P 04502423 00108033 04002623 00300303
P 04602823 00205383 04702a23 04100ca3
P 04101f23 00020463 00021463 ffffffff
P 008004ef ffffffff 06902023 06800567
P ffffffff ffffffff 06a02223 00001597
P 06b02423 ffffffff ffffffff ffffffff
D 0 80f27a91
# lui, addi, sub then stored
T 00 0 0 0 0
T 04 0 0 0 0
T 08 0 0 0 0
T 0c 0 0 0 0
T 10 1 40 f 1234567b
T 14 0 0 0 0
T 18 1 44 f 00000001
T 1c 0 0 0 0
T 20 1 48 f fffffffe
T 24 0 0 0 0
T 28 1 4c f 00000000
# lb and lhu from word 0, then sb and sh
T 2c 0 0 0 0
T 30 1 50 f ffffff80
T 34 0 0 0 0
T 38 1 54 f 000080f2
T 3c 1 59 2 78787878
T 40 1 5e c 56785678
# branches, jal and jalr with their link registers
T 44 0 0 0 0
T 48 0 0 0 0
T 50 0 0 0 0
T 58 1 60 f 00000054
T 5c 0 0 0 0
T 68 1 64 f 00000060
T 6c 0 0 0 0
T 70 1 68 f 0000106c
# unsupported opcode, core holds its pc
T 74 0 0 0 0
T 74 0 0 0 0
T 74 0 0 0 0
